// ==== cache_proj.f ====
hdl/cache_pkg.sv
hdl/cache_controller.sv
hdl/cache_line_store.sv
hdl/cache_top.sv
verification/tb_main_memory.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log

rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f cache_proj.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1

grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb
    import cache_pkg::*;
();

    localparam int line_index_w = 3;
    localparam int tag_w        = mem_addr_w - line_index_w;
    localparam int lines        = 1 << line_index_w;
    localparam int directed_ops = 9;
    localparam int random_ops   = 600;
    localparam int cycle_ns     = 40;
    localparam int watchdog_ns  = (directed_ops + random_ops) * 14 * cycle_ns + 8 * cycle_ns;

    logic      clk;
    logic      proc_reset;
    proc_req_t proc_req;
    logic      proc_stall;
    word_t     proc_rdata;
    mem_req_t  mem_req;
    line_t     mem_rdata;
    logic      mem_ready;
    int        mem_errors;

    int        seed;
    int        errors;
    int        refill_count;
    int        wb_count;

    word_t             model_mem [proc_addr_t];             // last written value per word
    logic [tag_w-1:0]  model_tag [lines];
    logic [lines-1:0]  model_valid;
    logic [lines-1:0]  model_dirty;

    cache_top #(
        .line_index_w (line_index_w)
    ) dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    tb_main_memory mem (
        .clk             (clk),
        .proc_reset      (proc_reset),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_ready       (mem_ready),
        .protocol_errors (mem_errors)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic word_t init_word(input proc_addr_t addr);
        init_word = {addr, 2'b11} ^ 32'h9e37_79b9;
    endfunction

    function automatic line_t init_line(input mem_addr_t line_addr);
        int k;
        for (k = 0; k < 4; k++)
            init_line[k*word_w +: word_w] = init_word({line_addr, word_offset_t'(k)});
    endfunction

    function automatic word_t model_word(input proc_addr_t addr);
        if (model_mem.exists(addr))
            model_word = model_mem[addr];
        else
            model_word = init_word(addr);
    endfunction

    function automatic line_t model_line(input mem_addr_t line_addr);
        int k;
        for (k = 0; k < 4; k++)
            model_line[k*word_w +: word_w] = model_word({line_addr, word_offset_t'(k)});
    endfunction

    function automatic logic [tag_w-1:0] pool_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    pool_tag = '0;
            2'd1:    pool_tag = tag_w'(32'h0000_0001);
            2'd2:    pool_tag = tag_w'(32'h00a5_3c17);
            default: pool_tag = ~tag_w'(32'h0000_0001);
        endcase
    endfunction

    function automatic proc_addr_t make_addr(input logic [1:0] sel,
                                             input logic [line_index_w-1:0] idx,
                                             input word_offset_t off);
        make_addr = {pool_tag(sel), idx, off};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mem_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // one processor access, returns after the cycle where it completes
    task automatic do_access(input logic is_write, input proc_addr_t addr, input word_t wdata);
        mem_addr_t               line_addr;
        logic [line_index_w-1:0] idx;
        logic                    expect_hit;
        int                      waits;
        line_addr  = addr[proc_addr_w-1:offset_w];
        idx        = line_addr[line_index_w-1:0];
        expect_hit = model_valid[idx] && (model_tag[idx] == line_addr[mem_addr_w-1:line_index_w]);
        waits      = 0;
        @(posedge clk);
        proc_req <= '{read: !is_write, write: is_write, addr: addr, wdata: wdata};
        @(negedge clk);
        while (proc_stall)
        begin
            waits++;
            @(negedge clk);
        end
        if (expect_hit && waits != 0)
            report_failure("access to a resident line was stalled");
        if (!expect_hit && waits == 0)
            report_failure("access to a missing line completed without a stall");
        if (is_write)
        begin
            model_mem[addr]  = wdata;
            model_dirty[idx] = 1'b1;
        end
        else
        begin
            check_word("proc_rdata", proc_rdata, model_word(addr));
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        proc_req <= '0;
    endtask

    // memory transfers happen at the edge after a negedge with mem_ready high
    always @(negedge clk)
    begin
        if (!proc_reset)
        begin
            if (mem_req.read && mem_req.write)
                report_failure("memory read and write requested in the same cycle");
            if (mem_ready && mem_req.write)
                handle_write_back();
            else if (mem_ready && mem_req.read)
                handle_refill();
        end
    end

    task automatic handle_write_back();
        logic [line_index_w-1:0] idx;
        mem_addr_t               victim;
        idx    = proc_req.addr[line_index_w+offset_w-1:offset_w];
        victim = {model_tag[idx], idx};
        if (!(model_valid[idx] && model_dirty[idx]))
            report_failure("write-back of a line that is not dirty");
        check_mem_addr("mem_req.addr", mem_req.addr, victim);
        check_line("mem_req.wdata", mem_req.wdata, model_line(victim));
        model_dirty[idx] = 1'b0;
        wb_count++;
    endtask

    task automatic handle_refill();
        logic [line_index_w-1:0] idx;
        mem_addr_t               line_addr;
        line_addr = proc_req.addr[proc_addr_w-1:offset_w];
        idx       = line_addr[line_index_w-1:0];
        if (model_valid[idx] && model_dirty[idx])
            report_failure("refill issued before the dirty line was written back");
        check_mem_addr("mem_req.addr", mem_req.addr, line_addr);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = line_addr[mem_addr_w-1:line_index_w];
        model_dirty[idx] = 1'b0;
        refill_count++;
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        int         r;
        int         reads_before;
        int         wbs_before;
        proc_addr_t addr;
        seed         = 32'h27f7_f9cb;
        errors       = 0;
        refill_count = 0;
        wb_count     = 0;
        model_valid  = '0;
        model_dirty  = '0;
        proc_req     = '0;
        proc_reset   = 1'b1;
        repeat (8) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        if (proc_stall || mem_req.read || mem_req.write)
            report_failure("stall or memory request active after reset");

        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd1), '0);   // cold miss
        if (refill_count != 1)
            report_failure("first read did not refill exactly once");

        reads_before = refill_count;
        wbs_before   = wb_count;
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd3), '0);
        if (refill_count != reads_before || wb_count != wbs_before)
            report_failure("read of a resident line went to memory");

        do_access(1'b1, make_addr(2'd0, 3'd2, 2'd3), 32'hcafe_0123);
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd3), '0);
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd0), '0);
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd1), '0);
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd2), '0);

        wbs_before = wb_count;
        do_access(1'b0, make_addr(2'd1, 3'd2, 2'd1), '0);   // evicts the dirty line
        if (wb_count != wbs_before + 1)
            report_failure("conflict miss on a dirty line did not write back once");
        do_access(1'b0, make_addr(2'd0, 3'd2, 2'd3), '0);   // written word comes back

        repeat (random_ops)
        begin
            r    = $random(seed);
            addr = make_addr(r[1:0], r[4:2], r[6:5]);
            do_access(r[8], addr, $random(seed));
        end
        go_idle();
        repeat (4) @(posedge clk);

        $display("errors: %0d checks, %0d memory protocol", errors, mem_errors);
        if (errors == 0 && mem_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/tb_main_memory.sv ====
`timescale 1ns/1ns

module tb_main_memory
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     proc_reset,
    input  mem_req_t mem_req,
    output line_t    mem_rdata,
    output logic     mem_ready,
    output int       protocol_errors
);

    line_t    lines [mem_addr_t];                           // lines written back so far
    mem_req_t held;
    logic     busy;
    int       delay;
    int       seed;

    initial
    begin
        seed      = 32'h27f7_f9cb;
        mem_ready = 1'b0;
        mem_rdata = '0;
    end

    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            busy            <= 1'b0;
            mem_ready       <= 1'b0;
            mem_rdata       <= '0;
            delay           <= 0;
            protocol_errors <= 0;
        end
        else
        begin
            mem_ready <= 1'b0;
            if (mem_ready)
            begin
                busy <= 1'b0;                               // request dropped at this edge
            end
            else if (!busy)
            begin
                if (mem_req.read || mem_req.write)
                begin
                    busy  <= 1'b1;
                    held  <= mem_req;
                    delay <= 1 + ($random(seed) & 3);
                end
            end
            else
            begin
                if (mem_req != held)
                begin
                    protocol_errors <= protocol_errors + 1;
                    $display("memory request changed before mem_ready at %0t", $time);
                end
                if (delay == 1)
                begin
                    mem_ready <= 1'b1;
                    if (held.write)
                        lines[held.addr] = held.wdata;
                    else if (lines.exists(held.addr))
                        mem_rdata <= lines[held.addr];
                    else
                        mem_rdata <= cache_tb.init_line(held.addr);   // never written
                end
                else
                begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ns

module cache_top
    import cache_pkg::*;
#(
    parameter int line_index_w = 3                          // 8 lines
)
(
    input  logic      clk,
    input  logic      proc_reset,
    input  proc_req_t proc_req,
    output logic      proc_stall,
    output word_t     proc_rdata,
    output mem_req_t  mem_req,
    input  line_t     mem_rdata,
    input  logic      mem_ready
);

    lookup_t lookup;
    logic    fill;
    logic    write_word;

    cache_controller #(
        .line_index_w (line_index_w)
    ) u_controller (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .lookup     (lookup),
        .mem_ready  (mem_ready),
        .fill       (fill),
        .write_word (write_word),
        .proc_stall (proc_stall),
        .mem_req    (mem_req)
    );

    cache_line_store #(
        .line_index_w (line_index_w)
    ) u_line_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .fill       (fill),
        .write_word (write_word),
        .mem_rdata  (mem_rdata),
        .lookup     (lookup),
        .rdata      (proc_rdata)
    );

endmodule

// ==== hdl/cache_line_store.sv ====
`timescale 1ns/1ns

module cache_line_store
    import cache_pkg::*;
#(
    parameter int line_index_w = 3
)
(
    input  logic      clk,
    input  logic      proc_reset,
    input  proc_req_t proc_req,
    input  logic      fill,
    input  logic      write_word,
    input  line_t     mem_rdata,
    output lookup_t   lookup,
    output word_t     rdata
);

    localparam int tag_w = mem_addr_w - line_index_w;
    localparam int lines = 1 << line_index_w;

    logic [tag_w-1:0]        tag_mem [lines];
    line_t                   data_mem [lines];
    logic [lines-1:0]        valid;
    logic [lines-1:0]        dirty;

    proc_addr_t              addr;
    logic [line_index_w-1:0] index;
    logic [tag_w-1:0]        req_tag;
    word_offset_t            offset;
    logic [tag_w-1:0]        stored_tag;
    line_t                   stored_line;

    assign addr    = proc_req.addr;
    assign offset  = addr[offset_w-1:0];
    assign index   = addr[line_index_w+offset_w-1:offset_w];
    assign req_tag = addr[proc_addr_w-1:line_index_w+offset_w];

    assign stored_tag  = tag_mem[index];
    assign stored_line = data_mem[index];

    assign lookup.hit         = valid[index] && (stored_tag == req_tag);
    assign lookup.dirty       = valid[index] && dirty[index];
    assign lookup.victim_addr = {stored_tag, index};       // where the old line lives
    assign lookup.line        = stored_line;

    // word k at bits 32k+31 down to 32k
    assign rdata = stored_line[offset*word_w +: word_w];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (fill)
        begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;                           // fresh copy from memory
        end
        else if (write_word)
        begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tag_mem[index]  <= req_tag;
            data_mem[index] <= mem_rdata;
        end
        else if (write_word)
        begin
            data_mem[index][offset*word_w +: word_w] <= proc_req.wdata;   // merge one word
        end
    end

    a_fill_write_excl : assert property (
        @(posedge clk) disable iff (proc_reset)
        !(fill && write_word)
    ) else $error("fill and word write in the same cycle");

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller
    import cache_pkg::*;
#(
    parameter int line_index_w = 3
)
(
    input  logic      clk,
    input  logic      proc_reset,
    input  proc_req_t proc_req,
    input  lookup_t   lookup,
    input  logic      mem_ready,
    output logic      fill,
    output logic      write_word,
    output logic      proc_stall,
    output mem_req_t  mem_req
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    mem_req_t    mem_req_next;
    logic        proc_active;
    mem_addr_t   miss_addr;

    logic        req_read;
    logic        req_write;
    mem_addr_t   req_addr;
    line_t       req_wdata;

    assign proc_active = proc_req.read | proc_req.write;
    assign miss_addr   = proc_req.addr[proc_addr_w-1:offset_w];   // line being accessed

    // only a hit in compare lets the access through
    assign proc_stall = proc_active && !((state == compare) && lookup.hit);
    assign write_word = (state == compare) && proc_req.write && lookup.hit;
    assign fill       = (state == allocate) && mem_ready;

    assign mem_req = '{read: req_read, write: req_write, addr: req_addr, wdata: req_wdata};

    always_comb
    begin
        state_next   = state;
        mem_req_next = mem_req;
        case (state)
            compare:
            begin
                if (proc_active && !lookup.hit)
                begin
                    if (lookup.dirty)
                    begin
                        state_next         = write_back;        // evict first
                        mem_req_next.write = 1'b1;
                        mem_req_next.addr  = lookup.victim_addr;
                        mem_req_next.wdata = lookup.line;
                    end
                    else
                    begin
                        state_next        = allocate;
                        mem_req_next.read = 1'b1;
                        mem_req_next.addr = miss_addr;
                    end
                end
            end
            write_back:
            begin
                if (mem_ready)
                begin
                    // victim accepted, refill starts next cycle
                    state_next         = allocate;
                    mem_req_next.write = 1'b0;
                    mem_req_next.read  = 1'b1;
                    mem_req_next.addr  = miss_addr;
                end
            end
            allocate:
            begin
                if (mem_ready)
                begin
                    state_next        = compare;            // retried as a hit
                    mem_req_next.read = 1'b0;
                end
            end
            default:
            begin
                state_next        = compare;
                mem_req_next.read  = 1'b0;
                mem_req_next.write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= compare;
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            req_read  <= mem_req_next.read;
            req_write <= mem_req_next.write;
        end
    end

    always_ff @(posedge clk)
    begin
        req_addr  <= mem_req_next.addr;
        req_wdata <= mem_req_next.wdata;
    end

    a_mem_req_onehot : assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write)
    ) else $error("memory read and write requested together");

    a_mem_req_hold : assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req)
    ) else $error("memory request changed before mem_ready");

    // the processor is stalled for the whole miss, so its index must match
    a_mem_req_slot : assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) |->
            mem_req.addr[line_index_w-1:0] ==
            proc_req.addr[line_index_w+offset_w-1:offset_w]
    ) else $error("memory request outside the index slot of the access");

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    localparam int word_w      = 32;
    localparam int line_w      = 128;
    localparam int proc_addr_w = 30;
    localparam int offset_w    = 2;                         // four words per line
    localparam int mem_addr_w  = proc_addr_w - offset_w;

    typedef logic [word_w-1:0]      word_t;
    typedef logic [line_w-1:0]      line_t;
    typedef logic [proc_addr_w-1:0] proc_addr_t;            // word address
    typedef logic [mem_addr_w-1:0]  mem_addr_t;             // line address
    typedef logic [offset_w-1:0]    word_offset_t;

    // processor side, held by the processor while stalled
    typedef struct packed {
        logic       read;
        logic       write;
        proc_addr_t addr;
        word_t      wdata;
    } proc_req_t;

    typedef struct packed {
        logic      read;
        logic      write;
        mem_addr_t addr;
        line_t     wdata;
    } mem_req_t;

    // state of the line addressed by the current request
    typedef struct packed {
        logic      hit;
        logic      dirty;
        mem_addr_t victim_addr;                             // stored tag and index
        line_t     line;
    } lookup_t;

    typedef enum logic [1:0] {
        compare,
        write_back,
        allocate
    } ctrl_state_t;

endpackage
